// ==== design/byte_fifo.sv ====
//----------------------------------------------------------
// Byte FIFO, 1K x 8
// Pointers, occupancy count, flags and registered read
//----------------------------------------------------------
`timescale 1ns/1ps

module byte_fifo
  import comm_ctrl_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  clear_i,                // Host clear, drops contents
  input  logic  push_i,
  input  byte_t push_data_i,
  input  logic  pop_i,
  output byte_t pop_data_o,
  output logic  empty_o,
  output logic  full_o,
  output logic  half_o
);

  localparam int unsigned DEPTH = 1 << FIFO_AW;

  byte_t        mem [DEPTH];
  fifo_addr_t   wr_addr_q;
  fifo_addr_t   rd_addr_q;
  logic [FIFO_AW:0] count_q;            // 0 to DEPTH
  byte_t        pop_data_q;
  logic         push_ok, pop_ok;

  assign push_ok = push_i & ~full_o;    // Full drops the byte
  assign pop_ok  = pop_i & ~empty_o;

  //----------------------------------------------------------
  // Pointers and count
  //----------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset || clear_i)
    begin
      wr_addr_q <= '0;
      rd_addr_q <= '0;
      count_q   <= '0;
    end
    else
    begin
      if (push_ok)
        wr_addr_q <= wr_addr_q + 1'b1;
      if (pop_ok)
        rd_addr_q <= rd_addr_q + 1'b1;
      case ({push_ok, pop_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;    // Both or neither
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk)
  begin
    if (push_ok)
      mem[wr_addr_q] <= push_data_i;
    if (pop_ok)
      pop_data_q <= mem[rd_addr_q];     // Valid the cycle after pop
  end

  assign pop_data_o = pop_data_q;

  // Flags
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == (FIFO_AW+1)'(DEPTH));
  assign half_o  = (count_q >= (FIFO_AW+1)'(DEPTH / 2));

  // Feed side only pops bytes that are there
  a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
    pop_i |-> !empty_o);

endmodule

// ==== design/byte_unpacker.sv ====
//----------------------------------------------------------
// Byte unpacker
// Four FIFO pushes per data word, MSB first
//----------------------------------------------------------
`timescale 1ns/1ps

module byte_unpacker
  import comm_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      data_strb_i,
  input  reg_word_t data_word_i,
  output logic      push_o,
  output byte_t     push_data_o
);

  reg_word_t  word_q;                   // Latched host word
  logic [6:0] dly_q;                    // Strobe delay chain

  always_ff @(posedge clk)
  begin
    if (reset)
      dly_q <= '0;
    else
      dly_q <= {dly_q[5:0], data_strb_i};
  end

  always_ff @(posedge clk)
  begin
    if (data_strb_i)
      word_q <= data_word_i;
  end

  // Pushes on alternate taps
  assign push_o = dly_q[0] | dly_q[2] | dly_q[4] | dly_q[6];

  always_comb
  begin
    if (dly_q[0])
      push_data_o = word_q[31:24];
    else if (dly_q[2])
      push_data_o = word_q[23:16];
    else if (dly_q[4])
      push_data_o = word_q[15:8];
    else
      push_data_o = word_q[7:0];        // Last tap
  end

  // Host spaces data writes past the whole chain
  a_no_strobe_busy: assert property (@(posedge clk) disable iff (reset)
    data_strb_i |-> (dly_q == '0));

endmodule

// ==== design/comm_ctrl_pkg.sv ====
//----------------------------------------------------------
// Communications controller shared definitions
// Register map, payload types and timing constants
//----------------------------------------------------------
package comm_ctrl_pkg;

  // Payload and address types
  typedef logic [31:0] reg_word_t;              // Host register data
  typedef logic [3:0]  reg_addr_t;              // Host register address
  typedef logic [7:0]  byte_t;                  // FIFO payload

  localparam int unsigned FIFO_AW = 10;         // 1024 entries
  typedef logic [FIFO_AW-1:0] fifo_addr_t;

  localparam logic [15:0] FPGA_VERSION = 16'h0003;

  //----------------------------------------------------------
  // Register map
  //----------------------------------------------------------
  localparam reg_addr_t REG_CTRL       = 4'd0;  // Holds, scratch / board status
  localparam reg_addr_t REG_VERSION    = 4'd1;
  localparam reg_addr_t REG_STATUS     = 4'd2;  // FIFO flags
  localparam reg_addr_t REG_FIFO_CLEAR = 4'd3;
  localparam reg_addr_t REG_FIFO_DATA  = 4'd4;  // Four bytes per write

  //----------------------------------------------------------
  // Timing
  //----------------------------------------------------------
  localparam int unsigned LED_TICK_CYCLES      = 25_000_000; // Heartbeat half period
  localparam int unsigned SEQ_TICK_CYCLES      = 12_500_000; // Sequencer tick
  localparam int unsigned CONFIG_RELEASE_TICKS = 12;
  localparam int unsigned RESET_RELEASE_TICKS  = 14;
  localparam int unsigned LOAD_HOLD_CYCLES     = 60;         // Player load strobe

endpackage

// ==== design/comm_ctrl_top.sv ====
//----------------------------------------------------------
// Communications controller top level
// Host registers, target sequencing, heartbeat, byte feed
//----------------------------------------------------------
`timescale 1ns/1ps

module comm_ctrl_top
  import comm_ctrl_pkg::*;
#(
  parameter int unsigned LED_TICK = LED_TICK_CYCLES,
  parameter int unsigned SEQ_TICK = SEQ_TICK_CYCLES
) (
  input  logic       clk,
  input  logic       reset,
  // Host register port
  input  logic       wr_strb_i,
  input  reg_addr_t  wr_addr_i,
  input  reg_word_t  wr_data_i,
  input  logic       rd_strb_i,
  input  reg_addr_t  rd_addr_i,
  output reg_word_t  rd_data_o,
  output logic       rd_rdy_o,
  // Board and target status
  input  logic [8:0] board_id_i,
  input  logic       target_ready_i,
  input  logic       discrete1_i,
  input  logic       discrete2_i,
  // JTAG player
  input  logic       player_rdy_i,
  output logic       load_o,
  output byte_t      load_data_o,
  // Target control and LED
  output logic       target_config_n_o,
  output logic       target_reset_n_o,
  output logic       status_led_n_o
);

  logic      led_tick, seq_tick;
  logic      led_q;                     // Heartbeat level
  logic      hold_config, hold_reset;
  logic      fifo_clear, data_strb;
  reg_word_t data_word;
  logic      push, pop;
  byte_t     push_data, pop_data;
  logic      fifo_empty, fifo_full, fifo_half;

  //----------------------------------------------------------
  // Heartbeat and power-up sequence
  //----------------------------------------------------------
  tick_timer #(.PERIOD(LED_TICK)) i_led_tick (
    .clk(clk), .reset(reset), .tick_o(led_tick)
  );

  always_ff @(posedge clk)
  begin
    if (reset)
      led_q <= 1'b0;
    else if (led_tick)
      led_q <= ~led_q;
  end

  assign status_led_n_o = led_q;

  tick_timer #(.PERIOD(SEQ_TICK)) i_seq_tick (
    .clk(clk), .reset(reset), .tick_o(seq_tick)
  );

  startup_sequencer i_seq (
    .clk(clk), .reset(reset), .tick_i(seq_tick),
    .hold_config_i(hold_config), .hold_reset_i(hold_reset),
    .target_config_n_o(target_config_n_o), .target_reset_n_o(target_reset_n_o)
  );

  reg_bank i_regs (
    .clk(clk), .reset(reset),
    .wr_strb_i(wr_strb_i), .wr_addr_i(wr_addr_i), .wr_data_i(wr_data_i),
    .rd_strb_i(rd_strb_i), .rd_addr_i(rd_addr_i),
    .rd_data_o(rd_data_o), .rd_rdy_o(rd_rdy_o),
    .board_id_i(board_id_i), .target_ready_i(target_ready_i),
    .discrete1_i(discrete1_i), .discrete2_i(discrete2_i),
    .fifo_empty_i(fifo_empty), .fifo_full_i(fifo_full), .fifo_half_i(fifo_half),
    .hold_config_o(hold_config), .hold_reset_o(hold_reset),
    .fifo_clear_o(fifo_clear), .data_strb_o(data_strb), .data_word_o(data_word)
  );

  //----------------------------------------------------------
  // Byte path to the player
  //----------------------------------------------------------
  byte_unpacker i_unpack (
    .clk(clk), .reset(reset), .data_strb_i(data_strb), .data_word_i(data_word),
    .push_o(push), .push_data_o(push_data)
  );

  byte_fifo i_fifo (
    .clk(clk), .reset(reset), .clear_i(fifo_clear),
    .push_i(push), .push_data_i(push_data), .pop_i(pop), .pop_data_o(pop_data),
    .empty_o(fifo_empty), .full_o(fifo_full), .half_o(fifo_half)
  );

  feed_ctrl i_feed (
    .clk(clk), .reset(reset), .player_rdy_i(player_rdy_i), .fifo_empty_i(fifo_empty),
    .pop_o(pop), .pop_data_i(pop_data), .load_o(load_o), .load_data_o(load_data_o)
  );

endmodule

// ==== design/feed_ctrl.sv ====
//----------------------------------------------------------
// Player feed controller
// Pops one byte per player ready, stretched load strobe
//----------------------------------------------------------
`timescale 1ns/1ps

module feed_ctrl
  import comm_ctrl_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  player_rdy_i,
  input  logic  fifo_empty_i,
  output logic  pop_o,
  input  byte_t pop_data_i,
  output logic  load_o,
  output byte_t load_data_o
);

  localparam int unsigned HW = $clog2(LOAD_HOLD_CYCLES);

  typedef enum logic [2:0] {
    S_IDLE,
    S_POP,                              // Pop issued to FIFO
    S_DATA_WAIT,                        // FIFO read latency
    S_HOLD,                             // Load strobe high
    S_WAIT_NRDY                         // Player must drop ready
  } feed_state_t;

  feed_state_t   state_q;
  logic [HW-1:0] hold_cnt_q;
  logic          rdy_low_q;             // Ready seen low since load
  byte_t         load_data_q;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state_q    <= S_IDLE;
      hold_cnt_q <= '0;
      rdy_low_q  <= 1'b0;
    end
    else
    begin
      if (state_q == S_POP)
        rdy_low_q <= 1'b0;
      else if (!player_rdy_i)
        rdy_low_q <= 1'b1;
      case (state_q)
        S_IDLE:      if (player_rdy_i && !fifo_empty_i) state_q <= S_POP;
        S_POP:       state_q <= fifo_empty_i ? S_IDLE : S_DATA_WAIT;
        S_DATA_WAIT:
        begin
          state_q    <= S_HOLD;
          hold_cnt_q <= '0;
        end
        S_HOLD:
        begin
          hold_cnt_q <= hold_cnt_q + 1'b1;
          if (hold_cnt_q == HW'(LOAD_HOLD_CYCLES - 1))
            state_q <= S_WAIT_NRDY;
        end
        S_WAIT_NRDY: if (rdy_low_q || !player_rdy_i) state_q <= S_IDLE;
        default:     state_q <= S_IDLE;
      endcase
    end
  end

  // Byte held stable for the slow player
  always_ff @(posedge clk)
  begin
    if (state_q == S_DATA_WAIT)
      load_data_q <= pop_data_i;
  end

  assign pop_o       = (state_q == S_POP) & ~fifo_empty_i; // Clear may empty it
  assign load_o      = (state_q == S_HOLD);
  assign load_data_o = load_data_q;

endmodule

// ==== design/reg_bank.sv ====
//----------------------------------------------------------
// Host register bank
// Write decode, control register, input capture, read mux
//----------------------------------------------------------
`timescale 1ns/1ps

module reg_bank
  import comm_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      wr_strb_i,
  input  reg_addr_t wr_addr_i,
  input  reg_word_t wr_data_i,
  input  logic      rd_strb_i,
  input  reg_addr_t rd_addr_i,
  output reg_word_t rd_data_o,
  output logic      rd_rdy_o,
  input  logic [8:0] board_id_i,        // Parity, revision, type
  input  logic      target_ready_i,
  input  logic      discrete1_i,
  input  logic      discrete2_i,
  input  logic      fifo_empty_i,
  input  logic      fifo_full_i,
  input  logic      fifo_half_i,
  output logic      hold_config_o,
  output logic      hold_reset_o,
  output logic      fifo_clear_o,
  output logic      data_strb_o,
  output reg_word_t data_word_o
);

  logic [15:0] ctrl_q;                  // Scratch plus hold bits
  logic        clear_q;
  logic        data_strb_q;
  reg_word_t   data_word_q;

  logic [8:0]  board_id_q;              // Input captures
  logic        ready_q, disc1_q, disc2_q;
  logic [2:0]  fifo_flags_q;            // half, full, empty

  logic        rd_strb_z1, rd_rdy_q;
  reg_addr_t   rd_addr_q;
  reg_word_t   rd_word;
  reg_word_t   rd_data_q;

  //----------------------------------------------------------
  // Writes
  //----------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      ctrl_q      <= '0;
      clear_q     <= 1'b0;
      data_strb_q <= 1'b0;
    end
    else
    begin
      if (wr_strb_i && wr_addr_i == REG_CTRL)
        ctrl_q <= wr_data_i[15:0];
      clear_q     <= wr_strb_i && wr_addr_i == REG_FIFO_CLEAR && wr_data_i[0];
      data_strb_q <= wr_strb_i && wr_addr_i == REG_FIFO_DATA;
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_strb_i && wr_addr_i == REG_FIFO_DATA)
      data_word_q <= wr_data_i;         // Word for the unpacker
  end

  assign hold_reset_o  = ctrl_q[0];
  assign hold_config_o = ctrl_q[1];
  assign fifo_clear_o  = clear_q;
  assign data_strb_o   = data_strb_q;
  assign data_word_o   = data_word_q;

  // Board and FIFO inputs, one cycle late
  always_ff @(posedge clk)
  begin
    board_id_q   <= board_id_i;
    ready_q      <= target_ready_i;
    disc1_q      <= discrete1_i;
    disc2_q      <= discrete2_i;
    fifo_flags_q <= {fifo_half_i, fifo_full_i, fifo_empty_i};
  end

  //----------------------------------------------------------
  // Reads, data and ready two cycles after the strobe
  //----------------------------------------------------------
  always_comb
  begin
    case (rd_addr_q)
      REG_CTRL:    rd_word = {ctrl_q, 3'b000, disc2_q, disc1_q, ready_q, 1'b0, board_id_q};
      REG_VERSION: rd_word = {16'h0000, FPGA_VERSION};
      REG_STATUS:  rd_word = {29'd0, fifo_flags_q};
      default:     rd_word = '0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rd_strb_z1 <= 1'b0;
      rd_rdy_q   <= 1'b0;
    end
    else
    begin
      rd_strb_z1 <= rd_strb_i;
      rd_rdy_q   <= rd_strb_z1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rd_strb_i)
      rd_addr_q <= rd_addr_i;
    if (rd_strb_z1)
      rd_data_q <= rd_word;             // Held until next read
  end

  assign rd_data_o = rd_data_q;
  assign rd_rdy_o  = rd_rdy_q;

endmodule

// ==== design/startup_sequencer.sv ====
//----------------------------------------------------------
// Target power-up sequencer
// Releases config, then logic reset, after counted ticks
//----------------------------------------------------------
`timescale 1ns/1ps

module startup_sequencer
  import comm_ctrl_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic tick_i,
  input  logic hold_config_i,           // Host override holds config low
  input  logic hold_reset_i,            // Host override holds reset low
  output logic target_config_n_o,
  output logic target_reset_n_o
);

  localparam int unsigned TW = $clog2(RESET_RELEASE_TICKS + 1);

  typedef enum logic [1:0] {
    S_HOLD_ALL,                         // Both lines held
    S_CONFIG_REL,                       // Config released
    S_RUNNING                           // Both released
  } seq_state_t;

  seq_state_t    state_q;
  logic [TW-1:0] tick_cnt_q;
  logic [TW-1:0] tick_cnt_nxt;

  assign tick_cnt_nxt = tick_cnt_q + 1'b1;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state_q    <= S_HOLD_ALL;
      tick_cnt_q <= '0;
    end
    else if (tick_i && state_q != S_RUNNING)
    begin
      tick_cnt_q <= tick_cnt_nxt;       // Counting stops once running
      if (state_q == S_HOLD_ALL && tick_cnt_nxt == TW'(CONFIG_RELEASE_TICKS))
        state_q <= S_CONFIG_REL;
      else if (state_q == S_CONFIG_REL && tick_cnt_nxt == TW'(RESET_RELEASE_TICKS))
        state_q <= S_RUNNING;
    end
  end

  // Host holds gate the sequenced levels
  assign target_config_n_o = (state_q != S_HOLD_ALL) & ~hold_config_i;
  assign target_reset_n_o  = (state_q == S_RUNNING)  & ~hold_reset_i;

  // Logic reset only released past the config release count
  a_reset_after_config: assert property (@(posedge clk) disable iff (reset)
    (state_q == S_RUNNING) |-> (tick_cnt_q > TW'(CONFIG_RELEASE_TICKS)));

endmodule

// ==== design/tick_timer.sv ====
//----------------------------------------------------------
// Tick timer
// Free-running counter, one-cycle tick every PERIOD cycles
//----------------------------------------------------------
`timescale 1ns/1ps

module tick_timer #(
  parameter int unsigned PERIOD = 8
) (
  input  logic clk,
  input  logic reset,
  output logic tick_o
);

  localparam int unsigned CW = (PERIOD > 1) ? $clog2(PERIOD) : 1;

  logic [CW-1:0] cnt_q;                 // Cycle count within period
  logic          last;                  // Final cycle of period

  assign last   = (cnt_q == CW'(PERIOD - 1));
  assign tick_o = last;

  always_ff @(posedge clk)
  begin
    if (reset)
      cnt_q <= '0;
    else if (last)
      cnt_q <= '0;                      // Wrap
    else
      cnt_q <= cnt_q + 1'b1;
  end

endmodule

// ==== dv/tb_comm_ctrl.sv ====
//----------------------------------------------------------
// Communications controller testbench
// Registers, sequencer, heartbeat and byte stream checks
//----------------------------------------------------------
`timescale 1ns/1ps

module tb_comm_ctrl
  import comm_ctrl_pkg::*;
();

  localparam int LED_TICK   = 16;         // Short ticks for simulation
  localparam int SEQ_TICK   = 8;
  localparam int FIFO_DEPTH = 1024;

  logic       clk, reset;
  logic       wr_strb_i, rd_strb_i, rd_rdy_o;
  reg_addr_t  wr_addr_i, rd_addr_i;
  reg_word_t  wr_data_i, rd_data_o;
  logic [8:0] board_id_i;
  logic       target_ready_i, discrete1_i, discrete2_i;
  logic       player_rdy_i, load_o;
  byte_t      load_data_o;
  logic       target_config_n_o, target_reset_n_o, status_led_n_o;

  logic [31:0] host_lfsr   = 32'h08e3ef95;
  logic [31:0] player_lfsr = 32'h08e3ef95;
  logic [31:0] gap_bits;
  byte_t       exp_q[$];                  // Predicted player byte stream
  string       cur_test;
  int          errors, err_mark, tests_run, tests_failed;
  int          cyc, load_len, low_cnt;
  int          config_rise = -1;
  int          reset_rise  = -1;
  logic        stall;                     // Player holds rdy low

  comm_ctrl_top #(.LED_TICK(LED_TICK), .SEQ_TICK(SEQ_TICK)) i_dut (
    .clk(clk), .reset(reset),
    .wr_strb_i(wr_strb_i), .wr_addr_i(wr_addr_i), .wr_data_i(wr_data_i),
    .rd_strb_i(rd_strb_i), .rd_addr_i(rd_addr_i),
    .rd_data_o(rd_data_o), .rd_rdy_o(rd_rdy_o),
    .board_id_i(board_id_i), .target_ready_i(target_ready_i),
    .discrete1_i(discrete1_i), .discrete2_i(discrete2_i),
    .player_rdy_i(player_rdy_i), .load_o(load_o), .load_data_o(load_data_o),
    .target_config_n_o(target_config_n_o), .target_reset_n_o(target_reset_n_o),
    .status_led_n_o(status_led_n_o)
  );

  always #5 clk = ~clk;                   // 10 ns period

  //----------------------------------------------------------
  // Random source, checks and reporting
  //----------------------------------------------------------
  // Galois LFSR step for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic next_random(inout logic [31:0] state, input int nbits,
                             output logic [31:0] val);
    int i;
    val = '0;
    for (i = 0; i < nbits; i++)
    begin
      state = lfsr_step(state);
      val   = {val[30:0], state[0]};
    end
  endtask

  task automatic check_word(input string what, input reg_word_t exp, input reg_word_t act);
    if (exp !== act)
    begin
      $display("[ERROR] %s %s: expected %h, actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_byte(input string what, input byte_t exp, input byte_t act);
    if (exp !== act)
    begin
      $display("[ERROR] %s %s: expected %h, actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_cycles(input string what, input int exp, input int act);
    if (exp != act)
    begin
      $display("[ERROR] %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_level(input string what, input logic exp, input logic act);
    if (exp !== act)
    begin
      $display("[ERROR] %s %s: expected %b, actual %b", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s: %s", cur_test, why);
    $display("Test FAILED");
    $finish;
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    err_mark = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == err_mark)
      $display("%s: pass", cur_test);
    else
    begin
      $display("%s: FAIL, %0d errors", cur_test, errors - err_mark);
      tests_failed++;
    end
  endtask

  // FIFO flags from the number of bytes held
  function automatic reg_word_t expected_status(input int held);
    reg_word_t s;
    s    = '0;
    s[0] = (held == 0);
    s[1] = (held == FIFO_DEPTH);
    s[2] = (held >= FIFO_DEPTH / 2);
    return s;
  endfunction

  //----------------------------------------------------------
  // Host model
  //----------------------------------------------------------
  task automatic write_reg(input reg_addr_t addr, input reg_word_t data);
    @(negedge clk);
    wr_strb_i = 1'b1;
    wr_addr_i = addr;
    wr_data_i = data;
    @(negedge clk);
    wr_strb_i = 1'b0;
  endtask

  task automatic read_reg(input reg_addr_t addr, output reg_word_t data);
    int n;
    @(negedge clk);
    rd_strb_i = 1'b1;
    rd_addr_i = addr;
    @(negedge clk);
    rd_strb_i = 1'b0;
    n = 1;
    while (!rd_rdy_o)
    begin
      @(negedge clk);
      n++;
      if (n > 20)
        abort_run("read ready never came back");
    end
    data = rd_data_o;
    check_cycles("read latency", 2, n);   // Strobe to ready
  endtask

  // Model drops bytes past a full FIFO as the DUT does
  task automatic model_push(input byte_t b);
    if (exp_q.size() < FIFO_DEPTH)
      exp_q.push_back(b);
  endtask

  task automatic send_words(input int count);
    logic [31:0] w;
    int i;
    for (i = 0; i < count; i++)
    begin
      next_random(host_lfsr, 32, w);
      model_push(w[31:24]);               // MSB first
      model_push(w[23:16]);
      model_push(w[15:8]);
      model_push(w[7:0]);
      write_reg(REG_FIFO_DATA, w);
      repeat (10) @(negedge clk);         // Unpacker needs 8 or more
    end
  endtask

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while (exp_q.size() != 0 || load_o || load_len != 0)
    begin
      @(negedge clk);
      n++;
      if (n > limit)
        abort_run("byte stream did not drain");
    end
  endtask

  task automatic measure_toggle(output int cycles);
    logic led;
    led    = status_led_n_o;
    cycles = 0;
    while (status_led_n_o == led)
    begin
      @(negedge clk);
      cycles++;
      if (cycles > 100)
        abort_run("heartbeat LED stopped toggling");
    end
  endtask

  //----------------------------------------------------------
  // Player model and output monitors
  //----------------------------------------------------------
  always @(negedge clk)
  begin
    if (reset)
    begin
      load_len     = 0;
      low_cnt      = 0;
      player_rdy_i = 1'b0;
    end
    else
    begin
      if (load_o)
      begin
        if (load_len == 0 && exp_q.size() == 0)
        begin
          $display("%s: load strobe with no byte expected", cur_test);
          errors++;
        end
        else if (load_len == 0)
          check_byte("load data", exp_q.pop_front(), load_data_o);
        load_len++;
      end
      else if (load_len != 0)
      begin
        check_cycles("load length", LOAD_HOLD_CYCLES, load_len);
        load_len = 0;
        next_random(player_lfsr, 3, gap_bits);
        low_cnt = 1 + gap_bits;           // rdy low 1 to 8 cycles
      end
      else if (low_cnt != 0)
        low_cnt--;
      player_rdy_i = !stall && (low_cnt == 0);
    end
  end

  always @(posedge clk)
  begin
    if (reset)
      cyc <= 0;
    else
      cyc <= cyc + 1;                     // Cycles since reset release
  end

  always @(negedge clk)
  begin
    if (config_rise < 0 && target_config_n_o === 1'b1)
      config_rise = cyc;
    if (reset_rise < 0 && target_reset_n_o === 1'b1)
      reset_rise = cyc;
  end

  //----------------------------------------------------------
  // Test sequence
  //----------------------------------------------------------
  initial
  begin
    reg_word_t   rd;
    reg_word_t   exp_word;
    logic [31:0] r;
    int          n;
    int          k;
    clk            = 1'b0;
    reset          = 1'b1;
    wr_strb_i      = 1'b0;
    wr_addr_i      = '0;
    wr_data_i      = '0;
    rd_strb_i      = 1'b0;
    rd_addr_i      = '0;
    board_id_i     = '0;
    target_ready_i = 1'b0;
    discrete1_i    = 1'b0;
    discrete2_i    = 1'b0;
    player_rdy_i   = 1'b0;
    stall          = 1'b0;
    cur_test       = "reset";
    repeat (8) @(negedge clk);
    reset = 1'b0;

    start_test("reset_values");
    read_reg(REG_VERSION, rd);
    check_word("version", 32'h0000_0003, rd);   // Version 3 in the low half
    read_reg(REG_STATUS, rd);
    check_word("status", expected_status(0), rd);
    end_test();

    start_test("sequencer");
    n = 0;
    while (reset_rise < 0)
    begin
      @(negedge clk);
      n++;
      if (n > 500)
        abort_run("target reset was never released");
    end
    check_cycles("config release", CONFIG_RELEASE_TICKS * SEQ_TICK, config_rise);
    check_cycles("reset release", RESET_RELEASE_TICKS * SEQ_TICK, reset_rise);
    write_reg(REG_CTRL, 32'h0000_0003);   // Host holds both lines
    repeat (2) @(negedge clk);
    check_level("config held", 1'b0, target_config_n_o);
    check_level("reset held", 1'b0, target_reset_n_o);
    write_reg(REG_CTRL, 32'h0000_0000);
    repeat (2) @(negedge clk);
    check_level("config free", 1'b1, target_config_n_o);
    check_level("reset free", 1'b1, target_reset_n_o);
    end_test();

    start_test("heartbeat");
    measure_toggle(n);                    // Align to an edge
    for (k = 0; k < 3; k++)
    begin
      measure_toggle(n);
      check_cycles("LED half period", LED_TICK, n);
    end
    end_test();

    start_test("board_regs");
    next_random(host_lfsr, 9, r);
    board_id_i = r[8:0];
    next_random(host_lfsr, 3, r);
    target_ready_i = r[0];
    discrete1_i    = r[1];
    discrete2_i    = r[2];
    next_random(host_lfsr, 32, r);
    write_reg(REG_CTRL, r);
    read_reg(REG_CTRL, rd);
    exp_word        = '0;
    exp_word[8:0]   = board_id_i;         // Type, revision, parity
    exp_word[10]    = target_ready_i;
    exp_word[11]    = discrete1_i;
    exp_word[12]    = discrete2_i;
    exp_word[31:16] = r[15:0];            // Scratch
    check_word("board word", exp_word, rd);
    read_reg(4'd7, rd);
    check_word("unmapped", 32'h0000_0000, rd);
    write_reg(REG_CTRL, 32'h0000_0000);
    end_test();

    start_test("byte_stream");
    send_words(16);
    wait_drain(64 * 100);
    end_test();

    // Stalled player lets the FIFO fill before a clear
    start_test("stall_full");
    stall = 1'b1;
    repeat (2) @(negedge clk);
    send_words(128);
    read_reg(REG_STATUS, rd);
    check_word("half status", expected_status(exp_q.size()), rd);
    send_words(132);
    read_reg(REG_STATUS, rd);
    check_word("full status", expected_status(exp_q.size()), rd);
    write_reg(REG_FIFO_CLEAR, 32'h0000_0001);
    exp_q.delete();
    repeat (3) @(negedge clk);
    read_reg(REG_STATUS, rd);
    check_word("cleared status", expected_status(0), rd);
    stall = 1'b0;
    send_words(4);                        // FIFO still works after clear
    wait_drain(16 * 100);
    end_test();

    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

// ==== src.f ====
design/comm_ctrl_pkg.sv
design/tick_timer.sv
design/startup_sequencer.sv
design/reg_bank.sv
design/byte_unpacker.sv
design/byte_fifo.sv
design/feed_ctrl.sv
design/comm_ctrl_top.sv
dv/tb_comm_ctrl.sv
